// File: Makefile
# Verilator build and run for the TileLink RAM testbench.

VERILATOR ?= verilator
TOP       ?= tb_tl_ram
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
verilog/tl_pkg.sv
verilog/tl_req_decode.sv
verilog/tl_amo_alu.sv
verilog/tl_ram_core.sv
verilog/tl_resp_queue.sv
verilog/tl_ram_top.sv
verif/tb_tl_ram.sv

// File: verif/tb_tl_ram.sv
`timescale 1ns/1ps

module tb_tl_ram;
    import tl_pkg::*;

    localparam int addr_w      = 12;
    localparam int source_w    = 4;
    localparam int words       = 2 ** (addr_w - 3);
    localparam int ready_limit = 200;
    localparam int drain_limit = 400;

    typedef logic [addr_w-4:0] word_t;

    typedef struct packed {
        logic [2:0]          opcode;
        logic [source_w-1:0] source;
        logic [2:0]          size;
        logic                denied;
        logic [63:0]         data;
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                a_valid;
    logic                a_ready;
    logic [2:0]          a_opcode;
    logic [2:0]          a_param;
    logic [2:0]          a_size;
    logic [source_w-1:0] a_source;
    logic [addr_w-1:0]   a_address;
    logic [7:0]          a_mask;
    logic [63:0]         a_data;
    logic                d_valid;
    logic                d_ready;
    tl_d_opcode_e        d_opcode;
    logic [2:0]          d_size;
    logic [source_w-1:0] d_source;
    logic                d_denied;
    logic [63:0]         d_data;

    expect_t     exp_q[$];
    expect_t     exp_head = '0;
    logic        exp_avail = 1'b0;
    logic        pop_pending = 1'b0;
    logic        stall_mode = 1'b0;
    int          outstanding = 0;
    logic        head_ok;
    logic [63:0] ref_mem [words];

    tl_ram_top #(.addr_w(addr_w), .source_w(source_w)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // data is only compared for responses that carry data.
    assign head_ok = exp_avail && (d_opcode == exp_head.opcode)
        && (d_source == exp_head.source) && (d_size == exp_head.size)
        && (d_denied == exp_head.denied)
        && (exp_head.opcode == access_ack || d_data == exp_head.data);

    task automatic report_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [63:0] fill_word(input int idx);
        return 64'h9e37_79b9_7f4a_7c15 * 64'(idx + 1);
    endfunction

    function automatic logic [63:0] random_word();
        return {$urandom, $urandom};
    endfunction

    // applies one request to the reference memory, byte by byte.
    task automatic model_access(input logic [2:0] opcode, input logic [2:0] param,
                                input logic [2:0] size, input logic [source_w-1:0] source,
                                input logic [addr_w-1:0] address, input logic [7:0] mask,
                                input logic [63:0] data, output expect_t e);
        word_t              word;
        logic [63:0]        old;
        logic [63:0]        upd;
        logic [63:0]        old_op;
        logic [63:0]        new_op;
        logic [63:0]        res;
        logic signed [63:0] s_old;
        logic signed [63:0] s_new;
        int                 nbytes;
        int                 off;
        word   = address[addr_w-1:3];
        off    = int'(address[2:0]);
        nbytes = 1 << size;
        old    = ref_mem[word];
        upd    = old;
        e.opcode = access_ack_data;
        e.source = source;
        e.size   = size;
        e.denied = 1'b0;
        e.data   = old;
        case (opcode)
            put_full_data, put_partial_data: begin
                e.opcode = access_ack;
                for (int k = 0; k < nbytes; k++) begin
                    if (mask[k]) upd[(off + k) * 8 +: 8] = data[k * 8 +: 8];
                end
            end
            get: begin
            end
            arithmetic_data, logical_data: begin
                old_op = '0;
                new_op = '0;
                for (int k = 0; k < nbytes; k++) begin
                    old_op[k * 8 +: 8] = old[(off + k) * 8 +: 8];
                    new_op[k * 8 +: 8] = data[k * 8 +: 8];
                end
                s_old = (nbytes == 4) ? {{32{old_op[31]}}, old_op[31:0]} : old_op;
                s_new = (nbytes == 4) ? {{32{new_op[31]}}, new_op[31:0]} : new_op;
                res = old_op;
                if (opcode == arithmetic_data) begin
                    case (param)
                        arith_add:  res = old_op + new_op;
                        arith_min:  if (s_new < s_old) res = new_op;
                        arith_max:  if (s_new > s_old) res = new_op;
                        arith_minu: if (new_op < old_op) res = new_op;
                        arith_maxu: if (new_op > old_op) res = new_op;
                        default:    res = old_op;
                    endcase
                end else begin
                    case (param)
                        logic_xor:  res = old_op ^ new_op;
                        logic_or:   res = old_op | new_op;
                        logic_and:  res = old_op & new_op;
                        default:    res = new_op;
                    endcase
                end
                for (int k = 0; k < nbytes; k++) begin
                    upd[(off + k) * 8 +: 8] = res[k * 8 +: 8];
                end
            end
            default: begin
                e.opcode = access_ack;
                e.denied = 1'b1;
            end
        endcase
        ref_mem[word] = upd;
    endtask

    // the monitor looks at mid-cycle, where both channels are stable.
    always @(negedge clk) begin : monitor
        expect_t e;
        if (rst_n) begin
            if (pop_pending && exp_q.size() != 0) void'(exp_q.pop_front());
            pop_pending = d_valid && d_ready;
            if (a_valid && a_ready) begin
                model_access(a_opcode, a_param, a_size, a_source, a_address, a_mask,
                             a_data, e);
                exp_q.push_back(e);
            end
            exp_avail   = (exp_q.size() != 0);
            exp_head    = exp_avail ? exp_q[0] : '0;
            outstanding = exp_q.size();
        end
    end

    // d_ready toggles in random stretches while stalling is on.
    initial begin
        int stretch;
        stretch = 0;
        d_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            if (!stall_mode) begin
                d_ready = 1'b1;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                d_ready = ($urandom % 2) == 0;
                stretch = int'($urandom % 6);
            end
        end
    end

    check_d_response: assert property (@(posedge clk) disable iff (!rst_n)
        (d_valid && d_ready) |-> head_ok)
    else begin
        $display("error at time %0t: D response does not match the expected one", $time);
        $display("  got op %0d src %0h size %0d denied %0b data %h", $sampled(d_opcode),
                 $sampled(d_source), $sampled(d_size), $sampled(d_denied), $sampled(d_data));
        $display("  expected op %0d src %0h size %0d denied %0b data %h", exp_head.opcode,
                 exp_head.source, exp_head.size, exp_head.denied, exp_head.data);
        report_failure();
    end

    // full means one request in decode and two responses stalled in the queue.
    ready_low_only_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !a_ready |-> (outstanding == 3 && !d_ready))
    else begin
        $display("error at time %0t: a_ready low while the pipeline has room", $time);
        report_failure();
    end

    task automatic send_request(input logic [2:0] opcode, input logic [2:0] param,
                                input logic [2:0] size, input logic [source_w-1:0] source,
                                input logic [addr_w-1:0] address, input logic [7:0] mask,
                                input logic [63:0] data);
        int waited;
        waited    = 0;
        a_valid   = 1'b1;
        a_opcode  = opcode;
        a_param   = param;
        a_size    = size;
        a_source  = source;
        a_address = address;
        a_mask    = mask;
        a_data    = data;
        @(negedge clk);
        while (!a_ready) begin
            waited++;
            if (waited > ready_limit) begin
                $display("timeout: a_ready stayed low for %0d cycles", ready_limit);
                report_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        a_valid = 1'b0;
    endtask

    task automatic put_word(input word_t word, input logic [63:0] data,
                            input logic [source_w-1:0] source);
        send_request(put_full_data, 3'd0, 3'd3, source, {word, 3'b000}, 8'hff, data);
    endtask

    task automatic get_word(input word_t word, input logic [source_w-1:0] source);
        send_request(get, 3'd0, 3'd3, source, {word, 3'b000}, 8'hff, 64'h0);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > drain_limit) begin
                $display("timeout: responses still outstanding after %0d cycles",
                         drain_limit);
                report_failure();
            end
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int                  sz;
        int                  off;
        int                  pick;
        logic [source_w-1:0] src;
        word_t               word;
        void'($urandom(40));
        rst_n     = 1'b0;
        a_valid   = 1'b0;
        a_opcode  = '0;
        a_param   = '0;
        a_size    = '0;
        a_source  = '0;
        a_address = '0;
        a_mask    = '0;
        a_data    = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        reset_state: assert (a_ready && !d_valid && !dut0.req_valid && !dut0.rsp_full)
        else begin
            $display("error at time %0t: handshake signals wrong after reset", $time);
            report_failure();
        end
        @(posedge clk);
        #2;

        // every word gets a known value first, since the array is not reset.
        for (int w = 0; w < words; w++) put_word(word_t'(w), fill_word(w), 4'(w));

        put_word(word_t'(5), random_word(), 4'h3);
        get_word(word_t'(5), 4'h7);

        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 8; o += (1 << s)) begin
                send_request(put_partial_data, 3'd0, 3'(s), 4'($urandom),
                             {word_t'(20), 3'(o)}, 8'($urandom), random_word());
                get_word(word_t'(20), 4'($urandom));
            end
        end

        // 4-byte operands sit at offset 0 or 4, 8-byte ones at offset 0.
        repeat (4) begin
            for (int p = 0; p < 5; p++) begin
                for (int c = 0; c < 3; c++) begin
                    sz  = (c == 2) ? 3 : 2;
                    off = (c == 1) ? 4 : 0;
                    src = 4'($urandom);
                    put_word(word_t'(40), random_word(), src);
                    send_request(arithmetic_data, 3'(p), 3'(sz), src,
                                 {word_t'(40), 3'(off)}, 8'hff, random_word());
                    get_word(word_t'(40), src);
                end
            end
        end

        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < 4; s++) begin
                off = int'(($urandom % (8 >> s)) << s);
                src = 4'($urandom);
                put_word(word_t'(44), random_word(), src);
                send_request(logical_data, 3'(p), 3'(s), src, {word_t'(44), 3'(off)},
                             8'hff, random_word());
                get_word(word_t'(44), src);
            end
        end

        stall_mode = 1'b1;
        repeat (80) begin
            pick = int'($urandom % 4);
            src  = 4'($urandom);
            word = word_t'($urandom);
            sz   = int'($urandom % 3);
            off  = int'(($urandom % (8 >> sz)) << sz);
            case (pick)
                0: put_word(word, random_word(), src);
                1: send_request(put_partial_data, 3'd0, 3'(sz), src, {word, 3'(off)},
                                8'($urandom), random_word());
                2: get_word(word, src);
                default: send_request(logical_data, 3'($urandom % 4), 3'd3, src,
                                      {word, 3'b000}, 8'hff, random_word());
            endcase
        end
        stall_mode = 1'b0;
        wait_drain();

        for (int op = 5; op < 8; op++) begin
            send_request(3'(op), 3'd0, 3'd3, 4'(op), {word_t'(50), 3'b000}, 8'hff,
                         random_word());
            get_word(word_t'(50), 4'(op));
        end

        wait_drain();
        if (exp_q.size() == 0 && !d_valid) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("error at time %0t: responses left over at the end", $time);
            report_failure();
        end
    end

endmodule

// File: verilog/tl_amo_alu.sv
`timescale 1ns/1ps

module tl_amo_alu (
    input  tl_pkg::tl_a_opcode_e        opcode,
    input  logic [2:0]                  param,
    input  logic [tl_pkg::size_w-1:0]   size,
    input  logic [2:0]                  offset,
    input  logic [tl_pkg::strb_w-1:0]   bytes,
    input  logic [tl_pkg::data_w-1:0]   old_word,
    input  logic [tl_pkg::data_w-1:0]   new_data,
    output logic [tl_pkg::data_w-1:0]   merged_word
);
    import tl_pkg::*;

    logic [data_w-1:0] lane_mask;
    logic [data_w-1:0] old_val;
    logic [data_w-1:0] new_val;
    logic [data_w-1:0] old_cmp;
    logic [data_w-1:0] new_cmp;
    logic [data_w-1:0] result;
    logic              new_lt_s;
    logic              new_gt_s;
    logic              new_lt_u;
    logic              new_gt_u;
    logic              update;

    // both operands are brought down to lane zero before the operation.
    assign lane_mask = byte_mask(bytes);
    assign old_val   = (old_word & lane_mask) >> (8 * offset);
    assign new_val   = (new_data & lane_mask) >> (8 * offset);

    // a 4-byte signed compare takes bit 31 as the sign.
    assign old_cmp = (size == 3'd2) ? {{32{old_val[31]}}, old_val[31:0]} : old_val;
    assign new_cmp = (size == 3'd2) ? {{32{new_val[31]}}, new_val[31:0]} : new_val;

    assign new_lt_s = $signed(new_cmp) < $signed(old_cmp);
    assign new_gt_s = $signed(new_cmp) > $signed(old_cmp);
    assign new_lt_u = new_val < old_val;
    assign new_gt_u = new_val > old_val;

    always_comb begin
        result = new_val;
        update = 1'b0;
        if (opcode == arithmetic_data) begin
            case (param)
                arith_add:  begin
                    result = old_val + new_val;
                    update = 1'b1;
                end
                arith_min:  update = new_lt_s;
                arith_max:  update = new_gt_s;
                arith_minu: update = new_lt_u;
                arith_maxu: update = new_gt_u;
                default:    update = 1'b0;
            endcase
        end else if (opcode == logical_data) begin
            update = 1'b1;
            case (param)
                logic_xor:  result = old_val ^ new_val;
                logic_or:   result = old_val | new_val;
                logic_and:  result = old_val & new_val;
                logic_swap: result = new_val;
                default:    update = 1'b0;
            endcase
        end
    end

    // carries out of the lane are cut off by the mask.
    assign merged_word = update ?
        ((old_word & ~lane_mask) | ((result << (8 * offset)) & lane_mask)) : old_word;

endmodule

// File: verilog/tl_pkg.sv
package tl_pkg;

    // one beat is a full 64-bit word, so every request is a single beat.
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;
    localparam int size_w = 3;

    typedef enum logic [2:0] {
        put_full_data    = 3'd0,
        put_partial_data = 3'd1,
        arithmetic_data  = 3'd2,
        logical_data     = 3'd3,
        get              = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        access_ack      = 3'd0,
        access_ack_data = 3'd1
    } tl_d_opcode_e;

    // a_param of an ArithmeticData request.
    typedef enum logic [2:0] {
        arith_min  = 3'd0,
        arith_max  = 3'd1,
        arith_minu = 3'd2,
        arith_maxu = 3'd3,
        arith_add  = 3'd4
    } tl_arith_e;

    // a_param of a LogicalData request.
    typedef enum logic [2:0] {
        logic_xor  = 3'd0,
        logic_or   = 3'd1,
        logic_and  = 3'd2,
        logic_swap = 3'd3
    } tl_logic_e;

    // widens a byte-lane mask to a bit mask over the whole beat.
    function automatic logic [data_w-1:0] byte_mask(input logic [strb_w-1:0] bytes);
        logic [data_w-1:0] mask;
        for (int i = 0; i < strb_w; i++) begin
            mask[i*8 +: 8] = {8{bytes[i]}};
        end
        return mask;
    endfunction

endpackage

// File: verilog/tl_ram_core.sv
`timescale 1ns/1ps

module tl_ram_core #(
    parameter int addr_w   = 12,
    parameter int source_w = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        req_valid,
    output logic                        req_take,
    input  tl_pkg::tl_a_opcode_e        req_opcode,
    input  logic [2:0]                  req_param,
    input  logic [tl_pkg::size_w-1:0]   req_size,
    input  logic [source_w-1:0]         req_source,
    input  logic [addr_w-4:0]           req_word,
    input  logic [2:0]                  req_offset,
    input  logic [tl_pkg::strb_w-1:0]   req_bytes,
    input  logic [tl_pkg::data_w-1:0]   req_data,

    output logic                        rsp_push,
    input  logic                        rsp_full,
    output tl_pkg::tl_d_opcode_e        rsp_opcode,
    output logic [tl_pkg::size_w-1:0]   rsp_size,
    output logic [source_w-1:0]         rsp_source,
    output logic                        rsp_denied,
    output logic [tl_pkg::data_w-1:0]   rsp_data
);
    import tl_pkg::*;

    localparam int words = 2 ** (addr_w - 3);

    logic [data_w-1:0] mem [words];
    logic [data_w-1:0] old_word;
    logic [data_w-1:0] merged_word;
    logic [data_w-1:0] put_word;
    logic [data_w-1:0] lane_mask;
    logic              is_put;
    logic              is_get;
    logic              is_atomic;
    logic              mem_we;

    assign old_word  = mem[req_word];
    assign is_put    = (req_opcode == put_full_data) || (req_opcode == put_partial_data);
    assign is_get    = (req_opcode == get);
    assign is_atomic = (req_opcode == arithmetic_data) || (req_opcode == logical_data);

    // a request is only taken when its response has a place to go.
    assign req_take = req_valid && !rsp_full;
    assign mem_we   = req_take && (is_put || is_atomic);

    assign lane_mask = byte_mask(req_bytes);
    assign put_word  = (old_word & ~lane_mask) | (req_data & lane_mask);

    tl_amo_alu u_amo_alu (
        .opcode      (req_opcode),
        .param       (req_param),
        .size        (req_size),
        .offset      (req_offset),
        .bytes       (req_bytes),
        .old_word    (old_word),
        .new_data    (req_data),
        .merged_word (merged_word)
    );

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[req_word] <= is_put ? put_word : merged_word;
        end
    end

    // the response leaves with the take and is registered by the queue.
    assign rsp_push   = req_take;
    assign rsp_opcode = (is_get || is_atomic) ? access_ack_data : access_ack;
    assign rsp_size   = req_size;
    assign rsp_source = req_source;
    assign rsp_denied = !(is_put || is_get || is_atomic);
    assign rsp_data   = (is_get || is_atomic) ? old_word : '0;

    // a request held back by a full queue must wait unchanged in the decode slot.
    req_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_take) |=> (req_valid && $stable(req_opcode)
            && $stable(req_param) && $stable(req_size) && $stable(req_source)
            && $stable(req_word) && $stable(req_offset) && $stable(req_bytes)
            && $stable(req_data)))
    else $error("decoded request changed while waiting for the core");

endmodule

// File: verilog/tl_ram_top.sv
`timescale 1ns/1ps

module tl_ram_top #(
    parameter int addr_w   = 12,
    parameter int source_w = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        a_valid,
    output logic                        a_ready,
    input  logic [2:0]                  a_opcode,
    input  logic [2:0]                  a_param,
    input  logic [tl_pkg::size_w-1:0]   a_size,
    input  logic [source_w-1:0]         a_source,
    input  logic [addr_w-1:0]           a_address,
    input  logic [tl_pkg::strb_w-1:0]   a_mask,
    input  logic [tl_pkg::data_w-1:0]   a_data,

    output logic                        d_valid,
    input  logic                        d_ready,
    output tl_pkg::tl_d_opcode_e        d_opcode,
    output logic [tl_pkg::size_w-1:0]   d_size,
    output logic [source_w-1:0]         d_source,
    output logic                        d_denied,
    output logic [tl_pkg::data_w-1:0]   d_data
);
    import tl_pkg::*;

    logic                req_valid;
    logic                req_take;
    tl_a_opcode_e        req_opcode;
    logic [2:0]          req_param;
    logic [size_w-1:0]   req_size;
    logic [source_w-1:0] req_source;
    logic [addr_w-4:0]   req_word;
    logic [2:0]          req_offset;
    logic [strb_w-1:0]   req_bytes;
    logic [data_w-1:0]   req_data;

    logic                rsp_push;
    logic                rsp_full;
    tl_d_opcode_e        rsp_opcode;
    logic [size_w-1:0]   rsp_size;
    logic [source_w-1:0] rsp_source;
    logic                rsp_denied;
    logic [data_w-1:0]   rsp_data;

    tl_req_decode #(.addr_w(addr_w), .source_w(source_w)) u_req_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_valid    (a_valid),
        .a_ready    (a_ready),
        .a_opcode   (a_opcode),
        .a_param    (a_param),
        .a_size     (a_size),
        .a_source   (a_source),
        .a_address  (a_address),
        .a_mask     (a_mask),
        .a_data     (a_data),
        .req_valid  (req_valid),
        .req_take   (req_take),
        .req_opcode (req_opcode),
        .req_param  (req_param),
        .req_size   (req_size),
        .req_source (req_source),
        .req_word   (req_word),
        .req_offset (req_offset),
        .req_bytes  (req_bytes),
        .req_data   (req_data)
    );

    tl_ram_core #(.addr_w(addr_w), .source_w(source_w)) u_ram_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_take   (req_take),
        .req_opcode (req_opcode),
        .req_param  (req_param),
        .req_size   (req_size),
        .req_source (req_source),
        .req_word   (req_word),
        .req_offset (req_offset),
        .req_bytes  (req_bytes),
        .req_data   (req_data),
        .rsp_push   (rsp_push),
        .rsp_full   (rsp_full),
        .rsp_opcode (rsp_opcode),
        .rsp_size   (rsp_size),
        .rsp_source (rsp_source),
        .rsp_denied (rsp_denied),
        .rsp_data   (rsp_data)
    );

    tl_resp_queue #(.source_w(source_w)) u_resp_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp_push   (rsp_push),
        .rsp_full   (rsp_full),
        .rsp_opcode (rsp_opcode),
        .rsp_size   (rsp_size),
        .rsp_source (rsp_source),
        .rsp_denied (rsp_denied),
        .rsp_data   (rsp_data),
        .d_valid    (d_valid),
        .d_ready    (d_ready),
        .d_opcode   (d_opcode),
        .d_size     (d_size),
        .d_source   (d_source),
        .d_denied   (d_denied),
        .d_data     (d_data)
    );

endmodule

// File: verilog/tl_req_decode.sv
`timescale 1ns/1ps

module tl_req_decode #(
    parameter int addr_w   = 12,
    parameter int source_w = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        a_valid,
    output logic                        a_ready,
    input  logic [2:0]                  a_opcode,
    input  logic [2:0]                  a_param,
    input  logic [tl_pkg::size_w-1:0]   a_size,
    input  logic [source_w-1:0]         a_source,
    input  logic [addr_w-1:0]           a_address,
    input  logic [tl_pkg::strb_w-1:0]   a_mask,
    input  logic [tl_pkg::data_w-1:0]   a_data,

    output logic                        req_valid,
    input  logic                        req_take,
    output tl_pkg::tl_a_opcode_e        req_opcode,
    output logic [2:0]                  req_param,
    output logic [tl_pkg::size_w-1:0]   req_size,
    output logic [source_w-1:0]         req_source,
    output logic [addr_w-4:0]           req_word,
    output logic [2:0]                  req_offset,
    output logic [tl_pkg::strb_w-1:0]   req_bytes,
    output logic [tl_pkg::data_w-1:0]   req_data
);
    import tl_pkg::*;

    logic [strb_w-1:0] size_mask;
    logic [2:0]        a_offset;
    logic [strb_w-1:0] a_bytes;
    logic [data_w-1:0] a_lanes;
    logic              a_fire;

    // a_size is log2 of the byte count, so size 3 covers all eight lanes.
    assign size_mask = {{4{a_size[1] & a_size[0]}}, {2{a_size[1]}},
                        a_size[1] | a_size[0], 1'b1};
    assign a_offset  = a_address[2:0];
    assign a_bytes   = (a_mask & size_mask) << a_offset;
    assign a_lanes   = a_data << (8 * a_offset);

    // the slot can refill in the same cycle that the core drains it.
    assign a_ready = !req_valid || req_take;
    assign a_fire  = a_valid && a_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (a_fire) begin
            req_valid <= 1'b1;
        end else if (req_take) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            req_opcode <= tl_a_opcode_e'(a_opcode);
            req_param  <= a_param;
            req_size   <= a_size;
            req_source <= a_source;
            req_word   <= a_address[addr_w-1:3];
            req_offset <= a_offset;
            req_bytes  <= a_bytes;
            req_data   <= a_lanes;
        end
    end

    // a stalled master must keep its beat unchanged until it is accepted.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (a_valid && !a_ready) |=> (a_valid && $stable(a_opcode) && $stable(a_param)
            && $stable(a_size) && $stable(a_source) && $stable(a_address)
            && $stable(a_mask) && $stable(a_data)))
    else $error("channel A beat changed while stalled");

endmodule

// File: verilog/tl_resp_queue.sv
`timescale 1ns/1ps

module tl_resp_queue #(
    parameter int source_w = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        rsp_push,
    output logic                        rsp_full,
    input  tl_pkg::tl_d_opcode_e        rsp_opcode,
    input  logic [tl_pkg::size_w-1:0]   rsp_size,
    input  logic [source_w-1:0]         rsp_source,
    input  logic                        rsp_denied,
    input  logic [tl_pkg::data_w-1:0]   rsp_data,

    output logic                        d_valid,
    input  logic                        d_ready,
    output tl_pkg::tl_d_opcode_e        d_opcode,
    output logic [tl_pkg::size_w-1:0]   d_size,
    output logic [source_w-1:0]         d_source,
    output logic                        d_denied,
    output logic [tl_pkg::data_w-1:0]   d_data
);
    import tl_pkg::*;

    tl_d_opcode_e      q_opcode [2];
    logic [size_w-1:0] q_size   [2];
    logic [source_w-1:0] q_source [2];
    logic              q_denied [2];
    logic [data_w-1:0] q_data   [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic              pop;

    assign d_valid = (count != 2'd0);
    assign pop     = d_valid && d_ready;

    // a full queue still takes a push when its head leaves in the same cycle.
    assign rsp_full = (count == 2'd2) && !d_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (rsp_push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            case ({rsp_push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_push) begin
            q_opcode[wr_ptr] <= rsp_opcode;
            q_size[wr_ptr]   <= rsp_size;
            q_source[wr_ptr] <= rsp_source;
            q_denied[wr_ptr] <= rsp_denied;
            q_data[wr_ptr]   <= rsp_data;
        end
    end

    assign d_opcode = q_opcode[rd_ptr];
    assign d_size   = q_size[rd_ptr];
    assign d_source = q_source[rd_ptr];
    assign d_denied = q_denied[rd_ptr];
    assign d_data   = q_data[rd_ptr];

    d_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (d_valid && !d_ready) |=> (d_valid && $stable(d_opcode) && $stable(d_size)
            && $stable(d_source) && $stable(d_denied) && $stable(d_data)))
    else $error("channel D beat changed while stalled");

endmodule
